//--- all.f
uart_line_pkg.sv
cmd_pkg.sv
cmd_splitter.sv
byte_fifo.sv
uart_tx.sv
uart_rx.sv
uart_cmd_bridge.sv
tb_clk_gen.sv
tb_uart_cmd_bridge.sv

//--- tb_uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge;

  localparam int clks_per_bit = 8;
  localparam int frame_clks   = 11 * clks_per_bit;
  localparam int n_tests      = 8;
  localparam int rdy_timeout  = 2000;

  localparam logic [1:0] flt_none = 2'd0;
  localparam logic [1:0] flt_par  = 2'd1;
  localparam logic [1:0] flt_stop = 2'd2;

  logic                          clk;
  logic                          rst_n;
  logic [cmd_pkg::cmd_width-1:0] cmd_in;
  logic                          cmd_vld;
  logic                          cmd_rdy;
  logic                          tx;
  logic                          rx;
  logic                          read_rdy;
  cmd_pkg::byte_t                read_data;
  logic                          frame_err;
  logic                          inject;
  logic                          line_drv;

  // stimulus table, first entry of each packed field in the top bits
  string       t_name  [n_tests];
  logic        t_inj   [n_tests];
  int          t_ncmd  [n_tests];
  logic [63:0] t_cmds  [n_tests];
  int          t_nrand [n_tests];
  int          t_nfrm  [n_tests];
  logic [15:0] t_frms  [n_tests];
  logic [3:0]  t_flts  [n_tests];
  int          t_nexp  [n_tests];
  logic [63:0] t_exp   [n_tests];
  logic        t_err   [n_tests];
  logic        t_bp    [n_tests];

  cmd_pkg::byte_t rx_q  [$];
  cmd_pkg::byte_t exp_q [$];
  int             err_cnt;
  int             max_wait;
  int             row_fails;
  int             pass_cnt;
  int             fail_cnt;
  integer         seed;

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  // rx hears either tx or the testbench line
  assign rx = inject ? line_drv : tx;

  uart_cmd_bridge #(
    .clks_per_bit (clks_per_bit),
    .parity       (uart_line_pkg::parity_odd),
    .fifo_depth   (4)
  ) i_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .frame_err (frame_err)
  );

  // receive monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if (read_rdy) begin
        rx_q.push_back(read_data);
      end
      if (frame_err) begin
        err_cnt = err_cnt + 1;
      end
    end
  end

  task automatic add_row(input int idx, input string name, input logic inj,
                         input int ncmd, input logic [63:0] cmds, input int nrand,
                         input int nfrm, input logic [15:0] frms, input logic [3:0] flts,
                         input int nexp, input logic [63:0] exp, input logic err,
                         input logic bp);
    t_name[idx]  = name;
    t_inj[idx]   = inj;
    t_ncmd[idx]  = ncmd;
    t_cmds[idx]  = cmds;
    t_nrand[idx] = nrand;
    t_nfrm[idx]  = nfrm;
    t_frms[idx]  = frms;
    t_flts[idx]  = flts;
    t_nexp[idx]  = nexp;
    t_exp[idx]   = exp;
    t_err[idx]   = err;
    t_bp[idx]    = bp;
  endtask

  task automatic load_table();
    // idx name inj | ncmd cmds nrand | nfrm frames faults | nexp bytes err bp
    add_row(0, "reset_idle", 0, 0, 64'h0, 0, 0, 16'h0, 4'h0, 0, 64'h0, 0, 0);
    add_row(1, "write_loopback", 0, 1, 64'hA53C_0000_0000_0000, 0,
            0, 16'h0, 4'h0, 2, 64'hA53C_0000_0000_0000, 0, 0);
    add_row(2, "read_loopback", 0, 1, 64'h5A7E_0000_0000_0000, 0,
            0, 16'h0, 4'h0, 1, 64'h5A00_0000_0000_0000, 0, 0);
    add_row(3, "write_then_read", 0, 2, 64'h8001_7F10_0000_0000, 0,
            0, 16'h0, 4'h0, 3, 64'h8001_7F00_0000_0000, 0, 0);
    add_row(4, "backpressure_rand", 0, 0, 64'h0, 4, 0, 16'h0, 4'h0, 0, 64'h0, 0, 1);
    add_row(5, "bad_parity", 1, 0, 64'h0, 0,
            1, 16'hC300, {flt_par, flt_none}, 0, 64'h0, 1, 0);
    add_row(6, "bad_stop_recover", 1, 0, 64'h0, 0,
            2, 16'h3C96, {flt_stop, flt_none}, 1, 64'h9600_0000_0000_0000, 1, 0);
    add_row(7, "good_inject", 1, 0, 64'h0, 0,
            1, 16'h8100, {flt_none, flt_none}, 1, 64'h8100_0000_0000_0000, 0, 0);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s: %s expected %0h actual %0h", name, what, expected, actual);
      row_fails++;
    end
  endtask

  task automatic offer_cmd(input logic [cmd_pkg::cmd_width-1:0] c);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!cmd_rdy && waited < rdy_timeout) begin
      waited++;
      @(negedge clk);
    end
    if (!cmd_rdy) begin
      $display("timeout: cmd_rdy stayed low for %0d cycles", rdy_timeout);
      row_fails++;
    end else begin
      @(posedge clk);
      cmd_in  <= c;
      cmd_vld <= 1'b1;
      // accept edge
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    if (waited > max_wait) begin
      max_wait = waited;
    end
  endtask

  task automatic send_frame(input cmd_pkg::byte_t d, input logic [1:0] flt);
    logic [10:0] frame;
    logic        par;
    // odd parity, data plus parity carry an odd number of ones
    par = ~^d;
    if (flt == flt_par) begin
      par = ~par;
    end
    frame = {(flt == flt_stop) ? 1'b0 : 1'b1, par, d, 1'b0};
    for (int b = 0; b < 11; b++) begin
      @(posedge clk);
      line_drv <= frame[b];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
    // idle gap so the next start bit is a fresh falling edge
    @(posedge clk);
    line_drv <= 1'b1;
    repeat (2 * clks_per_bit - 1) @(posedge clk);
  endtask

  task automatic run_row(input int i);
    logic [cmd_pkg::cmd_width-1:0] c;
    int                            waited;
    int                            limit;
    row_fails = 0;
    max_wait  = 0;
    err_cnt   = 0;
    rx_q.delete();
    exp_q.delete();
    @(negedge clk);
    check_value(t_name[i], "idle tx", 1, tx);
    check_value(t_name[i], "idle cmd_rdy", 1, cmd_rdy);
    @(posedge clk);
    inject <= t_inj[i];
    for (int k = 0; k < t_nexp[i]; k++) begin
      exp_q.push_back(t_exp[i][63 - 8*k -: 8]);
    end
    for (int k = 0; k < t_ncmd[i]; k++) begin
      offer_cmd(t_cmds[i][63 - 16*k -: 16]);
    end
    for (int k = 0; k < t_nrand[i]; k++) begin
      c = 16'($random(seed));
      c[cmd_pkg::wr_bit] = 1'b1;
      // a write sends its high byte then its low byte
      exp_q.push_back(c[15:8]);
      exp_q.push_back(c[7:0]);
      offer_cmd(c);
    end
    for (int k = 0; k < t_nfrm[i]; k++) begin
      send_frame(t_frms[i][15 - 8*k -: 8], t_flts[i][3 - 2*k -: 2]);
    end
    limit  = (exp_q.size() + 4) * frame_clks * 2;
    waited = 0;
    while ((rx_q.size() < exp_q.size() || (t_err[i] && err_cnt == 0)) && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (rx_q.size() < exp_q.size() || (t_err[i] && err_cnt == 0)) begin
      $display("timeout: %s got %0d of %0d bytes and %0d frame errors after %0d cycles",
               t_name[i], rx_q.size(), exp_q.size(), err_cnt, limit);
      row_fails++;
    end
    // quiet window catches extra bytes or pulses
    repeat (2 * frame_clks) @(negedge clk);
    check_value(t_name[i], "byte count", exp_q.size(), rx_q.size());
    for (int k = 0; k < exp_q.size() && k < rx_q.size(); k++) begin
      check_value(t_name[i], $sformatf("byte %0d", k), exp_q[k], rx_q[k]);
    end
    check_value(t_name[i], "frame_err seen", t_err[i], err_cnt != 0);
    if (t_bp[i]) begin
      assert (max_wait > 4) else begin
        $display("%s: cmd_rdy never held a command back", t_name[i]);
        row_fails++;
      end
    end
    if (row_fails == 0) begin
      pass_cnt++;
      $display("test %s ok", t_name[i]);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", t_name[i], row_fails);
    end
  endtask

  initial begin
    int waited;
    seed     = 32'hcb9b390a;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    inject   = 1'b0;
    line_drv = 1'b1;
    err_cnt  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    load_table();
    waited = 0;
    while (rst_n !== 1'b1 && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      fail_cnt++;
    end else begin
      for (int i = 0; i < n_tests; i++) begin
        run_row(i);
      end
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_uart_cmd_bridge

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real period_ns  = 4.0,
  parameter int  rst_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // release on a rising edge so the first active cycle is clean
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge #(
  parameter int                     clks_per_bit = uart_line_pkg::def_clks_per_bit,
  parameter uart_line_pkg::parity_e parity       = uart_line_pkg::parity_odd,
  parameter int                     fifo_depth   = 8
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire [cmd_pkg::cmd_width-1:0]  cmd_in,
  input  wire                           cmd_vld,
  output logic                          cmd_rdy,
  output logic                          tx,
  input  wire                           rx,
  output logic                          read_rdy,
  output cmd_pkg::byte_t                read_data,
  output logic                          frame_err
);

  logic           push;
  cmd_pkg::byte_t push_data;
  logic           pop;
  cmd_pkg::byte_t pop_data;
  logic           empty;
  logic           room;

  cmd_splitter i_cmd_splitter (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .room      (room),
    .cmd_rdy   (cmd_rdy),
    .push      (push),
    .push_data (push_data)
  );

  byte_fifo #(
    .fifo_depth (fifo_depth)
  ) i_byte_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    .room      (room)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit),
    .parity       (parity)
  ) i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .empty    (empty),
    .pop_data (pop_data),
    .pop      (pop),
    .tx       (tx)
  );

  // receive side is independent of the command chain
  uart_rx #(
    .clks_per_bit (clks_per_bit),
    .parity       (parity)
  ) i_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .frame_err (frame_err)
  );

endmodule : uart_cmd_bridge

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int                     clks_per_bit = uart_line_pkg::def_clks_per_bit,
  parameter uart_line_pkg::parity_e parity       = uart_line_pkg::parity_odd
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             rx,
  output logic            read_rdy,
  output cmd_pkg::byte_t  read_data,
  output logic            frame_err
);

  localparam int cnt_w    = $clog2(clks_per_bit + 1);
  localparam int idx_w    = $clog2(uart_line_pkg::data_bits + 1);
  localparam int half_bit = clks_per_bit / 2;

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop
  } state_t;

  state_t           state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic [cnt_w-1:0] bit_cnt;
  logic [idx_w-1:0] bit_idx;
  logic             bit_end;
  logic             par_ok;
  logic             exp_par;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev && !rx_sync;
  assign bit_end = (bit_cnt == cnt_w'(clks_per_bit - 1));
  assign exp_par = (parity == uart_line_pkg::parity_odd) ? ~^read_data : ^read_data;

  // data bits come lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == st_data && bit_end) begin
      read_data <= {rx_sync, read_data[7:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      par_ok    <= 1'b1;
      read_rdy  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      read_rdy  <= 1'b0;
      frame_err <= 1'b0;
      bit_cnt   <= bit_cnt + 1'b1;
      case (state)
        st_idle: begin
          bit_cnt <= '0;
          if (fall) begin
            state <= st_start;
          end
        end
        // start bit must still be low at mid-bit, else a glitch
        st_start: begin
          if (bit_cnt == cnt_w'(half_bit - 1)) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            par_ok  <= 1'b1;
            state   <= rx_sync ? st_idle : st_data;
          end
        end
        st_data: begin
          if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == idx_w'(uart_line_pkg::data_bits - 1)) begin
              state <= (parity == uart_line_pkg::parity_none) ? st_stop : st_parity;
            end
          end
        end
        st_parity: begin
          if (bit_end) begin
            bit_cnt <= '0;
            par_ok  <= (rx_sync == exp_par);
            state   <= st_stop;
          end
        end
        st_stop: begin
          if (bit_end) begin
            bit_cnt <= '0;
            state   <= st_idle;
            if (rx_sync && par_ok) begin
              read_rdy <= 1'b1;
            end else begin
              frame_err <= 1'b1;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  a_rdy_err_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(read_rdy && frame_err)
  );

endmodule : uart_rx

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int                     clks_per_bit = uart_line_pkg::def_clks_per_bit,
  parameter uart_line_pkg::parity_e parity       = uart_line_pkg::parity_odd
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  empty,
  input  wire cmd_pkg::byte_t  pop_data,
  output logic                 pop,
  output logic                 tx
);

  localparam int has_par    = (parity == uart_line_pkg::parity_none) ? 0 : 1;
  // start, data, optional parity, stop
  localparam int frame_bits = uart_line_pkg::data_bits + 2 + has_par;
  localparam int frame_w    = uart_line_pkg::data_bits + 3;
  localparam int cnt_w      = $clog2(clks_per_bit + 1);
  localparam int idx_w      = $clog2(frame_w + 1);

  logic               busy;
  logic [cnt_w-1:0]   bit_cnt;
  logic [idx_w-1:0]   bit_idx;
  logic [frame_w-1:0] frame_q;
  logic               bit_end;
  logic               frame_end;
  logic               par_bit;

  assign bit_end   = busy && (bit_cnt == cnt_w'(clks_per_bit - 1));
  assign frame_end = bit_end && (bit_idx == idx_w'(frame_bits - 1));

  // reload during the last stop cycle so frames follow without a gap
  assign pop = !empty && (!busy || frame_end);

  assign par_bit = (parity == uart_line_pkg::parity_odd) ? ~^pop_data : ^pop_data;

  // idle register is all ones, so the line rests high
  assign tx = frame_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      frame_q <= '1;
    end else if (pop) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
      if (has_par == 0) begin
        frame_q <= {2'b11, pop_data, 1'b0};
      end else begin
        frame_q <= {1'b1, par_bit, pop_data, 1'b0};
      end
    end else if (frame_end) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      frame_q <= '1;
    end else if (bit_end) begin
      bit_cnt <= '0;
      bit_idx <= bit_idx + 1'b1;
      frame_q <= {1'b1, frame_q[frame_w-1:1]};
    end else if (busy) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

endmodule : uart_tx

`default_nettype wire

//--- byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
  parameter int fifo_depth = 8
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  push,
  input  wire cmd_pkg::byte_t  push_data,
  input  wire                  pop,
  output cmd_pkg::byte_t       pop_data,
  output logic                 empty,
  output logic                 room
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = ptr_w + 1;

  cmd_pkg::byte_t   mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full  = (count == cnt_w'(fifo_depth));
  assign empty = (count == '0);
  // two free slots cover a whole write command
  assign room  = (count <= cnt_w'(fifo_depth - 2));

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // head is always on the output
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    full |-> !push
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    empty |-> !pop
  );

endmodule : byte_fifo

`default_nettype wire

//--- cmd_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_splitter (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire [cmd_pkg::cmd_width-1:0]  cmd_in,
  input  wire                           cmd_vld,
  input  wire                           room,
  output logic                          cmd_rdy,
  output logic                          push,
  output cmd_pkg::byte_t                push_data
);

  localparam int byte_w = $bits(cmd_pkg::byte_t);

  typedef enum logic [1:0] {
    st_idle,
    st_hi,
    st_lo
  } state_t;

  state_t                        state;
  logic [cmd_pkg::cmd_width-1:0] cmd_q;
  logic                          accept;

  // only take a command when both bytes are sure to fit
  assign cmd_rdy = (state == st_idle) && room;
  assign accept  = cmd_vld && cmd_rdy;

  assign push      = (state == st_hi) || (state == st_lo);
  assign push_data = (state == st_hi) ? cmd_q[cmd_pkg::cmd_width-1 -: byte_w]
                                      : cmd_q[byte_w-1:0];

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_hi;
          end
        end
        // read requests stop after the high byte
        st_hi: begin
          state <= cmd_q[cmd_pkg::wr_bit] ? st_lo : st_idle;
        end
        st_lo: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // high byte push still finds two free slots in the fifo
  a_push_had_room: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == st_hi) |-> room
  );

endmodule : cmd_splitter

`default_nettype wire

//--- cmd_pkg.sv
`default_nettype none

package cmd_pkg;

  // host command word
  localparam int cmd_width = 16;

  // set for a write, clear for a read request
  localparam int wr_bit = 15;

  // one byte on its way through the fifo and the line
  typedef logic [7:0] byte_t;

endpackage : cmd_pkg

`default_nettype wire

//--- uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

  // data bits per character, sent lsb first
  localparam int data_bits = 8;

  // parity slot between the last data bit and the stop bit
  typedef enum logic [1:0] {
    parity_none = 2'd0,
    parity_even = 2'd1,
    parity_odd  = 2'd2
  } parity_e;

  // clocks per bit when the top level is left at its default
  localparam int def_clks_per_bit = 16;

endpackage : uart_line_pkg

`default_nettype wire
